// ==== design/vector_pkg.sv ====
package vector_pkg;

	//////////////////////////////
	// Widths
	//////////////////////////////

	localparam int idx_w     = 4;	// Colour index and palette address
	localparam int color_w   = 8;	// Packed palette byte, BBGGGRRR
	localparam int port_w    = 8;	// Parallel port level
	localparam int rgb_w     = 4;	// One VGA channel
	localparam int pal_depth = 16;

	// Field positions inside a palette byte
	localparam int red_lsb   = 0;
	localparam int green_lsb = 3;
	localparam int blue_lsb  = 6;

	//////////////////////////////
	// Types
	//////////////////////////////

	// Who drives the palette address this cycle
	typedef enum logic [1:0] {
		src_pixel   = 2'd0,
		src_border  = 2'd1,
		src_palette = 2'd2
	} color_src_e;

endpackage

// ==== design/port_latch.sv ====
`timescale 1ns/1ps

module port_latch (
	input  logic                                clk24,
	input  logic                                mreset,
	input  logic                                retrace,
	input  logic [vector_pkg::port_w-1:0]       ppi_pa,
	input  logic [vector_pkg::port_w-1:0]       ppi_pb,
	input  logic                                palette_wr,
	input  logic [vector_pkg::color_w-1:0]      palette_data,
	output logic [vector_pkg::port_w-1:0]       scroll,
	output logic                                mode512,
	output logic [vector_pkg::port_w-1:0]       kbd_rowselect,
	output logic [vector_pkg::idx_w-1:0]        border_idx,
	output logic [vector_pkg::idx_w-1:0]        pal_addr,
	output logic [vector_pkg::color_w-1:0]      pal_value,
	output logic                                pal_wren
);

	//////////////////////////////
	// Port A and B steering
	//////////////////////////////

	// Same two buses carry different things depending on the beam phase
	always_ff @(posedge clk24) begin
		if (mreset) begin
			scroll        <= '0;
			mode512       <= 1'b0;
			kbd_rowselect <= '0;
			border_idx    <= '0;
			pal_addr      <= '0;
		end else if (retrace) begin
			kbd_rowselect <= ~ppi_pa;	// Row select is active low on the port
			pal_addr      <= ppi_pb[vector_pkg::idx_w-1:0];
		end else begin
			scroll     <= ppi_pa;
			border_idx <= ppi_pb[vector_pkg::idx_w-1:0];
			mode512    <= ppi_pb[4];
		end
	end

	//////////////////////////////
	// Palette port $0C
	//////////////////////////////

	// Strobe becomes a registered one-cycle write pulse
	always_ff @(posedge clk24) begin
		if (mreset) begin
			pal_value <= '0;
			pal_wren  <= 1'b0;
		end else begin
			pal_wren <= palette_wr;
			if (palette_wr) begin
				pal_value <= palette_data;	// Held until the next write
			end
		end
	end

	// A long write pulse only comes from a long strobe
	property wren_single_pulse;
		@(posedge clk24) disable iff (mreset)
			(pal_wren && $past(pal_wren)) |-> ($past(palette_wr) && $past(palette_wr, 2));
	endproperty

	wren_single_pulse_a : assert property (wren_single_pulse)
		else $error("pal_wren stretched without a matching palette_wr");

endmodule

// ==== design/color_select.sv ====
`timescale 1ns/1ps

module color_select (
	input  logic                                clk24,
	input  logic                                retrace,
	input  logic                                border,
	input  logic                                video_active,
	input  logic [vector_pkg::idx_w-1:0]        pixel_idx,
	input  logic [vector_pkg::idx_w-1:0]        border_idx,
	input  logic [vector_pkg::idx_w-1:0]        pal_addr,
	input  logic [vector_pkg::color_w-1:0]      pal_value,
	input  logic                                pal_wren,
	output logic [vector_pkg::idx_w-1:0]        sel_addr,
	output logic [vector_pkg::color_w-1:0]      sel_wdata,
	output logic                                sel_we,
	output logic                                sel_active
);

	vector_pkg::color_src_e src;

	//////////////////////////////
	// Source priority
	//////////////////////////////

	// Palette port wins during retrace and for any pending write
	always_comb begin
		if (retrace || pal_wren) begin
			src = vector_pkg::src_palette;
		end else if (border) begin
			src = vector_pkg::src_border;
		end else begin
			src = vector_pkg::src_pixel;
		end
	end

	//////////////////////////////
	// Stage 1 registers
	//////////////////////////////

	always_ff @(posedge clk24) begin
		case (src)
			vector_pkg::src_palette: sel_addr <= pal_addr;
			vector_pkg::src_border:  sel_addr <= border_idx;
			default:                 sel_addr <= pixel_idx;
		endcase
		sel_we     <= pal_wren;
		sel_wdata  <= pal_value;
		sel_active <= video_active;	// Blanking rides along with the address
	end

endmodule

// ==== design/palette_ram.sv ====
`timescale 1ns/1ps

module palette_ram (
	input  logic                                clk24,
	input  logic [vector_pkg::idx_w-1:0]        sel_addr,
	input  logic [vector_pkg::color_w-1:0]      sel_wdata,
	input  logic                                sel_we,
	input  logic                                sel_active,
	output logic [vector_pkg::color_w-1:0]      ram_color,
	output logic                                ram_active
);

	// 16 packed 3-3-2 colours
	logic [vector_pkg::color_w-1:0] mem [vector_pkg::pal_depth];

	//////////////////////////////
	// Write port
	//////////////////////////////

	always_ff @(posedge clk24) begin
		if (sel_we) begin
			mem[sel_addr] <= sel_wdata;
		end
	end

	//////////////////////////////
	// Read port
	//////////////////////////////

	// Write-first, so the entry being loaded shows up right away
	always_ff @(posedge clk24) begin
		if (sel_we) begin
			ram_color <= sel_wdata;
		end else begin
			ram_color <= mem[sel_addr];
		end
		ram_active <= sel_active;
	end

endmodule

// ==== design/rgb_expand.sv ====
`timescale 1ns/1ps

module rgb_expand (
	input  logic                                clk24,
	input  logic [vector_pkg::color_w-1:0]      ram_color,
	input  logic                                ram_active,
	output logic [vector_pkg::rgb_w-1:0]        vga_r,
	output logic [vector_pkg::rgb_w-1:0]        vga_g,
	output logic [vector_pkg::rgb_w-1:0]        vga_b
);

	logic [2:0] red;
	logic [2:0] green;
	logic [1:0] blue;

	// Unpack BBGGGRRR
	assign red   = ram_color[vector_pkg::red_lsb +: 3];
	assign green = ram_color[vector_pkg::green_lsb +: 3];
	assign blue  = ram_color[vector_pkg::blue_lsb +: 2];

	// Pad low bits with zeros, black outside the visible area
	always_ff @(posedge clk24) begin
		vga_r <= ram_active ? {red, 1'b0}   : '0;
		vga_g <= ram_active ? {green, 1'b0} : '0;
		vga_b <= ram_active ? {blue, 2'b00} : '0;
	end

	property blank_outside_active;
		@(posedge clk24) !ram_active |=> (vga_r == '0 && vga_g == '0 && vga_b == '0);
	endproperty

	blank_outside_active_a : assert property (blank_outside_active)
		else $error("RGB not blanked after inactive video");

endmodule

// ==== design/vector_video_top.sv ====
`timescale 1ns/1ps

module vector_video_top (
	input  logic                                clk24,
	input  logic                                mreset,
	input  logic [vector_pkg::port_w-1:0]       ppi_pa,
	input  logic [vector_pkg::port_w-1:0]       ppi_pb,
	input  logic                                retrace,
	input  logic                                palette_wr,
	input  logic [vector_pkg::color_w-1:0]      palette_data,
	input  logic [vector_pkg::idx_w-1:0]        pixel_idx,
	input  logic                                border,
	input  logic                                video_active,
	output logic [vector_pkg::port_w-1:0]       scroll,
	output logic                                mode512,
	output logic [vector_pkg::port_w-1:0]       kbd_rowselect,
	output logic [vector_pkg::rgb_w-1:0]        vga_r,
	output logic [vector_pkg::rgb_w-1:0]        vga_g,
	output logic [vector_pkg::rgb_w-1:0]        vga_b
);

	// Latched port fields
	logic [vector_pkg::idx_w-1:0]   border_idx;
	logic [vector_pkg::idx_w-1:0]   pal_addr;
	logic [vector_pkg::color_w-1:0] pal_value;
	logic                           pal_wren;

	// Stage 1 to stage 2
	logic [vector_pkg::idx_w-1:0]   sel_addr;
	logic [vector_pkg::color_w-1:0] sel_wdata;
	logic                           sel_we;
	logic                           sel_active;

	// Stage 2 to stage 3
	logic [vector_pkg::color_w-1:0] ram_color;
	logic                           ram_active;

	//////////////////////////////
	// Port side
	//////////////////////////////

	port_latch port_latch_i (
		.clk24         (clk24),
		.mreset        (mreset),
		.retrace       (retrace),
		.ppi_pa        (ppi_pa),
		.ppi_pb        (ppi_pb),
		.palette_wr    (palette_wr),
		.palette_data  (palette_data),
		.scroll        (scroll),
		.mode512       (mode512),
		.kbd_rowselect (kbd_rowselect),
		.border_idx    (border_idx),
		.pal_addr      (pal_addr),
		.pal_value     (pal_value),
		.pal_wren      (pal_wren)
	);

	//////////////////////////////
	// Colour pipeline
	//////////////////////////////

	color_select color_select_i (
		.clk24        (clk24),
		.retrace      (retrace),
		.border       (border),
		.video_active (video_active),
		.pixel_idx    (pixel_idx),
		.border_idx   (border_idx),
		.pal_addr     (pal_addr),
		.pal_value    (pal_value),
		.pal_wren     (pal_wren),
		.sel_addr     (sel_addr),
		.sel_wdata    (sel_wdata),
		.sel_we       (sel_we),
		.sel_active   (sel_active)
	);

	palette_ram palette_ram_i (
		.clk24      (clk24),
		.sel_addr   (sel_addr),
		.sel_wdata  (sel_wdata),
		.sel_we     (sel_we),
		.sel_active (sel_active),
		.ram_color  (ram_color),
		.ram_active (ram_active)
	);

	rgb_expand rgb_expand_i (
		.clk24      (clk24),
		.ram_color  (ram_color),
		.ram_active (ram_active),
		.vga_r      (vga_r),
		.vga_g      (vga_g),
		.vga_b      (vga_b)
	);

endmodule

// ==== testbench/tb_checker.sv ====
`timescale 1ns/1ps

module tb_checker (
	input  logic                           clk24,
	input  logic                           mreset,
	input  logic [vector_pkg::port_w-1:0]  ppi_pb,
	input  logic                           retrace,
	input  logic                           palette_wr,
	input  logic [vector_pkg::color_w-1:0] palette_data,
	input  logic [vector_pkg::idx_w-1:0]   pixel_idx,
	input  logic                           border,
	input  logic                           video_active,
	input  logic [vector_pkg::port_w-1:0]  scroll,
	input  logic                           mode512,
	input  logic [vector_pkg::port_w-1:0]  kbd_rowselect,
	input  logic [vector_pkg::rgb_w-1:0]   vga_r,
	input  logic [vector_pkg::rgb_w-1:0]   vga_g,
	input  logic [vector_pkg::rgb_w-1:0]   vga_b,
	input  logic [2:0]                     tag,
	input  logic [vector_pkg::port_w-1:0]  exp_scroll,
	input  logic                           exp_mode,
	input  logic [vector_pkg::port_w-1:0]  exp_kbd,
	output int                             checks,
	output int                             errors
);

	string names [8] = '{"idle", "reset", "ports", "palette", "readback", "border",
		"blanking", "pipeline"};
	int tag_checks [8] = '{default: 0};
	int tag_errors [8] = '{default: 0};
	int n_checks = 0;
	int n_errors = 0;

	// Reference palette, filled only by observed writes
	logic [vector_pkg::color_w-1:0]   pal [vector_pkg::pal_depth];
	logic [vector_pkg::pal_depth-1:0] pal_known = '0;

	// Port fields that feed the pipeline
	logic [vector_pkg::idx_w-1:0]   m_border_idx = '0;
	logic [vector_pkg::idx_w-1:0]   m_pal_addr = '0;
	logic [vector_pkg::color_w-1:0] m_pal_value = '0;
	logic                           m_pal_wren = 1'b0;

	// Pipeline copies, stage 1 to stage 3
	vector_pkg::color_src_e         src;
	logic [vector_pkg::idx_w-1:0]   s_addr = '0;
	logic [vector_pkg::color_w-1:0] s_wdata = '0;
	logic                           s_we = 1'b0;
	logic                           s_active = 1'b0;
	logic [vector_pkg::color_w-1:0] r_color = '0;
	logic                           r_active = 1'b0;
	logic                           r_known = 1'b0;
	logic [11:0]                    v_rgb = '0;
	logic                           v_known = 1'b0;
	logic [2:0]                     valid = '0;	// One bit per filled stage
	logic [2:0]                     p_tag = 3'd1;	// Row that the port registers show
	logic [2:0]                     s_tag = '0;
	logic [2:0]                     r_tag = '0;
	logic [2:0]                     v_tag = '0;

	assign checks = n_checks;
	assign errors = n_errors;

	// Packed BBGGGRRR into padded 4-bit channels
	function automatic logic [11:0] expand(input logic [7:0] c);
		return {c[2:0], 1'b0, c[5:3], 1'b0, c[7:6], 2'b00};
	endfunction

	task automatic compare_value(input logic [16:0] got, input logic [16:0] want,
			input string what, input logic [2:0] t);
		n_checks++;
		tag_checks[t]++;
		if (got !== want) begin
			n_errors++;
			tag_errors[t]++;
			$display("Error at %0t ns: %s is %h, expected %h", $time, what, got, want);
		end
	endtask

	always @(negedge clk24) begin
		logic [2:0] done_tag;
		compare_value({scroll, mode512, kbd_rowselect}, {exp_scroll, exp_mode, exp_kbd},
			"port registers", p_tag);
		p_tag = tag;
		if (valid[2] && v_known) begin
			compare_value({5'd0, vga_r, vga_g, vga_b}, {5'd0, v_rgb}, "rgb", v_tag);
		end
		done_tag = v_tag;

		//////////////////////////////
		// Advance the model one edge
		//////////////////////////////

		v_known = r_known || !r_active;	// Black needs no palette entry
		v_rgb   = r_active ? expand(r_color) : 12'h000;
		v_tag   = r_tag;

		r_known  = s_we || pal_known[s_addr];
		r_color  = s_we ? s_wdata : pal[s_addr];	// New data on a write
		r_active = s_active;
		r_tag    = s_tag;
		if (s_we) begin
			pal[s_addr]       = s_wdata;
			pal_known[s_addr] = 1'b1;
		end

		if (retrace || m_pal_wren) begin
			src = vector_pkg::src_palette;
		end else if (border) begin
			src = vector_pkg::src_border;
		end else begin
			src = vector_pkg::src_pixel;
		end
		case (src)
			vector_pkg::src_palette: s_addr = m_pal_addr;
			vector_pkg::src_border:  s_addr = m_border_idx;
			default:                 s_addr = pixel_idx;
		endcase
		s_we     = m_pal_wren;
		s_wdata  = m_pal_value;
		s_active = video_active;
		s_tag    = tag;
		valid    = {valid[1:0], 1'b1};

		// Retrace decides which field port B loads
		if (mreset) begin
			m_border_idx = '0;
			m_pal_addr   = '0;
			m_pal_value  = '0;
			m_pal_wren   = 1'b0;
		end else begin
			if (retrace) begin
				m_pal_addr = ppi_pb[3:0];
			end else begin
				m_border_idx = ppi_pb[3:0];
			end
			if (palette_wr) begin
				m_pal_value = palette_data;
			end
			m_pal_wren = palette_wr;
		end

		if (v_tag != done_tag && done_tag != 3'd0) begin
			$display("Test %s: %s, %0d checks, %0d errors", names[done_tag],
				(tag_errors[done_tag] == 0) ? "ok" : "failed", tag_checks[done_tag],
				tag_errors[done_tag]);
		end
	end

endmodule

// ==== testbench/tb_top.sv ====
`timescale 1ns/1ps

module tb_top;

	// One clock of stimulus plus the port registers expected after its edge
	typedef struct packed {
		logic [vector_pkg::port_w-1:0]  pa;
		logic [vector_pkg::port_w-1:0]  pb;
		logic                           retrace;
		logic                           wr;
		logic [vector_pkg::color_w-1:0] data;
		logic [vector_pkg::idx_w-1:0]   pix;
		logic                           border;
		logic                           active;
		logic [vector_pkg::port_w-1:0]  exp_scroll;
		logic                           exp_mode;
		logic [vector_pkg::port_w-1:0]  exp_kbd;
		logic [2:0]                     tag;
	} row_t;

	logic                           clk24;
	logic                           mreset;
	logic [vector_pkg::port_w-1:0]  ppi_pa;
	logic [vector_pkg::port_w-1:0]  ppi_pb;
	logic                           retrace;
	logic                           palette_wr;
	logic [vector_pkg::color_w-1:0] palette_data;
	logic [vector_pkg::idx_w-1:0]   pixel_idx;
	logic                           border;
	logic                           video_active;
	logic [vector_pkg::port_w-1:0]  scroll;
	logic                           mode512;
	logic [vector_pkg::port_w-1:0]  kbd_rowselect;
	logic [vector_pkg::rgb_w-1:0]   vga_r;
	logic [vector_pkg::rgb_w-1:0]   vga_g;
	logic [vector_pkg::rgb_w-1:0]   vga_b;

	logic [2:0]                    tag;
	logic [vector_pkg::port_w-1:0] exp_scroll;
	logic                          exp_mode;
	logic [vector_pkg::port_w-1:0] exp_kbd;
	int                            checks;
	int                            errors;
	int                            cycles = 0;

	row_t                          rows [$];
	logic [vector_pkg::port_w-1:0] trk_scroll = '0;
	logic                          trk_mode = 1'b0;
	logic [vector_pkg::port_w-1:0] trk_kbd = '0;

	vector_video_top vector_video_top_i (
		.clk24         (clk24),
		.mreset        (mreset),
		.ppi_pa        (ppi_pa),
		.ppi_pb        (ppi_pb),
		.retrace       (retrace),
		.palette_wr    (palette_wr),
		.palette_data  (palette_data),
		.pixel_idx     (pixel_idx),
		.border        (border),
		.video_active  (video_active),
		.scroll        (scroll),
		.mode512       (mode512),
		.kbd_rowselect (kbd_rowselect),
		.vga_r         (vga_r),
		.vga_g         (vga_g),
		.vga_b         (vga_b)
	);

	tb_checker tb_checker_i (.*);

	initial begin
		clk24 = 1'b0;
		forever #20 clk24 = ~clk24;
	end

	// Run limit grows with the table
	always @(posedge clk24) begin
		cycles++;
		if (cycles > 4 * rows.size() + 50) begin
			$display("Timeout after %0d cycles, the stimulus table never finished", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	function automatic logic [7:0] rnd8();
		return 8'($urandom);
	endfunction

	function automatic logic [3:0] rnd4();
		return 4'($urandom);
	endfunction

	task automatic add_row(input logic [7:0] pa, input logic [7:0] pb, input logic rt,
			input logic wr, input logic [7:0] data, input logic [3:0] pix, input logic brd,
			input logic act, input logic [2:0] t);
		row_t r;
		if (rt) begin
			trk_kbd = ~pa;	// Keyboard rows are active low
		end else begin
			trk_scroll = pa;
			trk_mode   = pb[4];
		end
		r = '{pa, pb, rt, wr, data, pix, brd, act, trk_scroll, trk_mode, trk_kbd, t};
		rows.push_back(r);
	endtask

	task automatic apply_row(input row_t r);
		ppi_pa       = r.pa;
		ppi_pb       = r.pb;
		retrace      = r.retrace;
		palette_wr   = r.wr;
		palette_data = r.data;
		pixel_idx    = r.pix;
		border       = r.border;
		video_active = r.active;
		tag          = r.tag;
	endtask

	initial begin
		int i;
		void'($urandom(32'hb5991587));
		mreset       = 1'b1;
		ppi_pa       = '0;
		ppi_pb       = '0;
		retrace      = 1'b0;
		palette_wr   = 1'b0;
		palette_data = '0;
		pixel_idx    = '0;
		border       = 1'b0;
		video_active = 1'b0;
		tag          = 3'd1;
		exp_scroll   = '0;
		exp_mode     = 1'b0;
		exp_kbd      = '0;

		//////////////////////////////
		// Stimulus table
		//////////////////////////////

		repeat (4) add_row(8'h00, 8'h00, 1'b0, 1'b0, 8'h00, 4'h0, 1'b0, 1'b0, 3'd1);
		repeat (8) add_row(rnd8(), rnd8(), 1'b0, 1'b0, 8'h00, 4'h0, 1'b0, 1'b0, 3'd2);
		repeat (4) add_row(rnd8(), rnd8(), 1'b1, 1'b0, 8'h00, 4'h0, 1'b0, 1'b0, 3'd2);
		for (i = 0; i < vector_pkg::pal_depth; i++) begin
			add_row(rnd8(), 8'(i), 1'b1, 1'b1, rnd8(), 4'h0, 1'b0, 1'b0, 3'd3);
		end
		add_row(8'h00, 8'h00, 1'b0, 1'b0, 8'h00, 4'h0, 1'b0, 1'b0, 3'd3);	// Last write drains
		for (i = 0; i < vector_pkg::pal_depth; i++) begin
			add_row(8'h00, 8'h00, 1'b0, 1'b0, 8'h00, 4'(i), 1'b0, 1'b1, 3'd4);
		end
		repeat (10) add_row(rnd8(), rnd8(), 1'b0, 1'b0, 8'h00, rnd4(), 1'b1, 1'b1, 3'd5);
		repeat (10) add_row(rnd8(), rnd8(), 1'b0, 1'b0, 8'h00, rnd4(), rnd8() > 8'h7f,
			1'b0, 3'd6);
		repeat (24) add_row(rnd8(), rnd8(), 1'b0, 1'b0, 8'h00, rnd4(), 1'b0, 1'b1, 3'd7);
		repeat (6) add_row(8'h00, 8'h00, 1'b0, 1'b0, 8'h00, 4'h0, 1'b0, 1'b0, 3'd0);

		repeat (5) @(posedge clk24);
		#2;
		mreset = 1'b0;
		foreach (rows[k]) begin
			apply_row(rows[k]);
			@(posedge clk24);
			#2;
			exp_scroll = rows[k].exp_scroll;	// Port outputs lag by one edge
			exp_mode   = rows[k].exp_mode;
			exp_kbd    = rows[k].exp_kbd;
		end

		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0 && checks > 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== files.f ====
design/vector_pkg.sv
design/port_latch.sv
design/color_select.sv
design/palette_ram.sv
design/rgb_expand.sv
design/vector_video_top.sv
testbench/tb_checker.sv
testbench/tb_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_top
RTL_TOP   ?= vector_video_top
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

RTL_SRCS ?= design/vector_pkg.sv design/port_latch.sv design/color_select.sv \
	design/palette_ram.sv design/rgb_expand.sv design/vector_video_top.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
